// File: rtl/sym_out_pkg.sv
package sym_out_pkg;

    // Symbol vector geometry.
    localparam int NUM_CHANNELS = 8;
    localparam int SYM_WIDTH = 3;
    localparam int WORD_WIDTH = NUM_CHANNELS * SYM_WIDTH;

    // FIFO sizing, one wrap bit on top of the address.
    localparam int FIFO_DEPTH = 16;
    localparam int PTR_WIDTH = $clog2(FIFO_DEPTH) + 1;

    // APB window.
    localparam int APB_AW = 4;
    localparam int APB_DW = 32;

    typedef enum logic [APB_AW-1:0] {
        REG_STATUS = 4'h0,  // Empty flag and word count.
        REG_DATA   = 4'h4,  // Head vector, read pops.
        REG_ID     = 4'h8   // Geometry constants.
    } apb_reg_e;

    typedef enum logic {
        RD_IDLE,
        RD_WAIT
    } rd_state_e;

endpackage

// File: rtl/sym_sync.sv
`timescale 1ns/1ps

module sym_sync #(
    parameter int WIDTH = 1
) (
    input  logic             i_clk,
    input  logic [WIDTH-1:0] i_d,
    output logic [WIDTH-1:0] o_q
);

    logic [WIDTH-1:0] meta;
    logic [WIDTH-1:0] stable;

    // Two flops in the destination domain.
    always_ff @(posedge i_clk) begin
        meta <= i_d;
        stable <= meta;
    end

    assign o_q = stable;

endmodule

// File: rtl/sym_async_fifo.sv
`timescale 1ns/1ps

module sym_async_fifo
    import sym_out_pkg::*;
(
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  logic                        i_push,
    input  logic signed [SYM_WIDTH-1:0] i_data [NUM_CHANNELS-1:0],
    output logic                        o_full,

    input  logic                        i_oclk,
    input  logic                        i_oreset,
    input  logic                        i_pop,
    output logic [WORD_WIDTH-1:0]       o_word,
    output logic                        o_empty,
    output logic [PTR_WIDTH-1:0]        o_count
);

    logic [WORD_WIDTH-1:0] mem [FIFO_DEPTH];
    logic [WORD_WIDTH-1:0] wr_word;

    logic [PTR_WIDTH-1:0] wr_bin;
    logic [PTR_WIDTH-1:0] wr_bin_next;
    logic [PTR_WIDTH-1:0] wr_gray;
    logic [PTR_WIDTH-1:0] wr_gray_next;
    logic [PTR_WIDTH-1:0] rd_gray_w;  // Read pointer seen by the write side.

    logic [PTR_WIDTH-1:0] rd_bin;
    logic [PTR_WIDTH-1:0] rd_bin_next;
    logic [PTR_WIDTH-1:0] rd_gray;
    logic [PTR_WIDTH-1:0] rd_gray_next;
    logic [PTR_WIDTH-1:0] wr_gray_r;  // Write pointer seen by the read side.

    logic push_ok;
    logic pop_ok;

    function automatic logic [PTR_WIDTH-1:0] gray_to_bin(input logic [PTR_WIDTH-1:0] g);
        logic [PTR_WIDTH-1:0] b;
        b[PTR_WIDTH-1] = g[PTR_WIDTH-1];
        for (int i = PTR_WIDTH - 2; i >= 0; i--) begin
            b[i] = b[i+1] ^ g[i];
        end
        return b;
    endfunction

    // Channel n lands at bits 3n+2:3n.
    always_comb begin
        for (int ii = 0; ii < NUM_CHANNELS; ii++) begin
            wr_word[SYM_WIDTH*ii +: SYM_WIDTH] = $unsigned(i_data[ii]);
        end
    end

    assign push_ok = i_push && !o_full;
    assign wr_bin_next = wr_bin + PTR_WIDTH'(push_ok);
    assign wr_gray_next = wr_bin_next ^ (wr_bin_next >> 1);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wr_bin <= '0;
            wr_gray <= '0;
        end else begin
            wr_bin <= wr_bin_next;
            wr_gray <= wr_gray_next;
        end
    end

    always_ff @(posedge i_clk) begin
        if (push_ok) begin
            mem[wr_bin[PTR_WIDTH-2:0]] <= wr_word;
        end
    end

    // Full when the top two gray bits differ and the rest match.
    assign o_full = (wr_gray == {~rd_gray_w[PTR_WIDTH-1 -: 2], rd_gray_w[PTR_WIDTH-3:0]});

    sym_sync #(
        .WIDTH(PTR_WIDTH)
    ) i_rptr_sync (
        .i_clk(i_clk),
        .i_d  (rd_gray),
        .o_q  (rd_gray_w)
    );

    assign pop_ok = i_pop && !o_empty;
    assign rd_bin_next = rd_bin + PTR_WIDTH'(pop_ok);
    assign rd_gray_next = rd_bin_next ^ (rd_bin_next >> 1);

    always_ff @(posedge i_oclk) begin
        if (i_oreset) begin
            rd_bin <= '0;
            rd_gray <= '0;
        end else begin
            rd_bin <= rd_bin_next;
            rd_gray <= rd_gray_next;
        end
    end

    sym_sync #(
        .WIDTH(PTR_WIDTH)
    ) i_wptr_sync (
        .i_clk(i_oclk),
        .i_d  (wr_gray),
        .o_q  (wr_gray_r)
    );

    assign o_empty = (rd_gray == wr_gray_r);
    assign o_word = mem[rd_bin[PTR_WIDTH-2:0]];  // Head word, no read latency.
    assign o_count = gray_to_bin(wr_gray_r) - rd_bin;

endmodule

// File: rtl/sym_apb_reader.sv
`timescale 1ns/1ps

module sym_apb_reader
    import sym_out_pkg::*;
(
    input  logic                  i_oclk,
    input  logic                  i_oreset,
    input  logic                  i_psel,
    input  logic                  i_penable,
    input  logic                  i_pwrite,
    input  logic [APB_AW-1:0]     i_paddr,
    input  logic [APB_DW-1:0]     i_pwdata,
    output logic [APB_DW-1:0]     o_prdata,
    output logic                  o_pready,
    output logic                  o_pslverr,

    input  logic [WORD_WIDTH-1:0] i_word,
    input  logic                  i_empty,
    input  logic [PTR_WIDTH-1:0]  i_count,
    output logic                  o_pop
);

    rd_state_e state;

    logic [APB_DW-1:0] rsp_data;
    logic              rsp_err;
    logic              rsp_pop;

    // Response for the transfer in its first access cycle.
    always_comb begin
        rsp_data = '0;
        rsp_err = 1'b0;
        rsp_pop = 1'b0;
        if (i_pwrite) begin
            rsp_data = i_pwdata;  // Echo only, nothing is written.
        end else begin
            case (apb_reg_e'(i_paddr))
                REG_STATUS: begin
                    rsp_data[0] = i_empty;
                    rsp_data[8 +: PTR_WIDTH] = i_count;
                end
                REG_DATA: begin
                    if (i_empty) begin
                        rsp_err = 1'b1;  // Nothing to read.
                    end else begin
                        rsp_data[WORD_WIDTH-1:0] = i_word;
                        rsp_pop = 1'b1;
                    end
                end
                REG_ID: begin
                    rsp_data[7:0] = 8'(NUM_CHANNELS);
                    rsp_data[15:8] = 8'(SYM_WIDTH);
                end
                default: rsp_err = 1'b1;
            endcase
        end
    end

    always_ff @(posedge i_oclk) begin
        if (i_oreset) begin
            state <= RD_IDLE;
            o_pready <= 1'b0;
            o_pslverr <= 1'b0;
            o_pop <= 1'b0;
        end else begin
            o_pready <= 1'b0;
            o_pslverr <= 1'b0;
            o_pop <= 1'b0;
            case (state)
                RD_IDLE: begin
                    if (i_psel && !i_penable) begin
                        state <= RD_WAIT;  // Setup seen.
                    end
                end
                RD_WAIT: begin
                    state <= RD_IDLE;
                    if (i_psel && i_penable) begin
                        o_pready <= 1'b1;
                        o_pslverr <= rsp_err;
                        o_pop <= rsp_pop;  // Pops in the completing cycle.
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_oclk) begin
        if (state == RD_WAIT) begin
            o_prdata <= rsp_data;
        end
    end

endmodule

// File: rtl/sym_out_top.sv
`timescale 1ns/1ps

module sym_out_top
    import sym_out_pkg::*;
(
    input  logic                        i_clk,
    input  logic                        i_oclk,
    input  logic                        i_reset,
    input  logic                        i_push,
    input  logic signed [SYM_WIDTH-1:0] i_data [NUM_CHANNELS-1:0],
    output logic                        o_full,

    input  logic                        i_psel,
    input  logic                        i_penable,
    input  logic                        i_pwrite,
    input  logic [APB_AW-1:0]           i_paddr,
    input  logic [APB_DW-1:0]           i_pwdata,
    output logic [APB_DW-1:0]           o_prdata,
    output logic                        o_pready,
    output logic                        o_pslverr
);

    logic                  oreset;  // Reset in the readout domain.
    logic                  rd_pop;
    logic [WORD_WIDTH-1:0] rd_word;
    logic                  rd_empty;
    logic [PTR_WIDTH-1:0]  rd_count;

    sym_sync #(
        .WIDTH(1)
    ) i_oreset_sync (
        .i_clk(i_oclk),
        .i_d  (i_reset),
        .o_q  (oreset)
    );

    sym_async_fifo i_fifo (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_push  (i_push),
        .i_data  (i_data),
        .o_full  (o_full),
        .i_oclk  (i_oclk),
        .i_oreset(oreset),
        .i_pop   (rd_pop),
        .o_word  (rd_word),
        .o_empty (rd_empty),
        .o_count (rd_count)
    );

    sym_apb_reader i_reader (
        .i_oclk   (i_oclk),
        .i_oreset (oreset),
        .i_psel   (i_psel),
        .i_penable(i_penable),
        .i_pwrite (i_pwrite),
        .i_paddr  (i_paddr),
        .i_pwdata (i_pwdata),
        .o_prdata (o_prdata),
        .o_pready (o_pready),
        .o_pslverr(o_pslverr),
        .i_word   (rd_word),
        .i_empty  (rd_empty),
        .i_count  (rd_count),
        .o_pop    (rd_pop)
    );

endmodule

// File: bench/sym_out_props.sv
`timescale 1ns/1ps

module sym_out_props
    import sym_out_pkg::*;
(
    input logic                 i_clk,
    input logic                 i_reset,
    input logic                 i_pop,
    input logic                 i_empty,
    input logic                 i_pready,
    input logic                 i_full,
    input logic [PTR_WIDTH-1:0] i_wr_bin
);

    // Pop only with data in the FIFO.
    pop_not_empty: assert property (@(posedge i_clk) disable iff (i_reset)
        i_pop |-> !i_empty)
        else $error("pop issued while the FIFO is empty");

    pready_single: assert property (@(posedge i_clk) disable iff (i_reset)
        i_pready |=> !i_pready)
        else $error("pready high in two consecutive cycles");

    full_holds_ptr: assert property (@(posedge i_clk) disable iff (i_reset)
        i_full |=> i_wr_bin == $past(i_wr_bin))
        else $error("write pointer advanced while full");

endmodule

bind sym_apb_reader sym_out_props i_reader_props (
    .i_clk   (i_oclk),
    .i_reset (i_oreset),
    .i_pop   (o_pop),
    .i_empty (i_empty),
    .i_pready(o_pready),
    .i_full  (1'b0),
    .i_wr_bin('0)
);

bind sym_async_fifo sym_out_props i_fifo_props (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .i_pop   (1'b0),
    .i_empty (1'b0),
    .i_pready(1'b0),
    .i_full  (o_full),
    .i_wr_bin(wr_bin)
);

// File: bench/tb_sym_out.sv
`timescale 1ns/1ps

module tb_sym_out
    import sym_out_pkg::*;
;

    localparam int N_RANDOM = 40;
    localparam int PLANNED_TRANSFERS = 2 + 3 + 4 * N_RANDOM + 3 + 3 + 2 * FIFO_DEPTH + 2;
    localparam int CYCLE_LIMIT = 20 * PLANNED_TRANSFERS;

    logic                        i_clk = 1'b0;
    logic                        i_oclk = 1'b0;
    logic                        i_reset;
    logic                        i_push;
    logic signed [SYM_WIDTH-1:0] i_data [NUM_CHANNELS-1:0];
    logic                        o_full;
    logic                        i_psel;
    logic                        i_penable;
    logic                        i_pwrite;
    logic [APB_AW-1:0]           i_paddr;
    logic [APB_DW-1:0]           i_pwdata;
    logic [APB_DW-1:0]           o_prdata;
    logic                        o_pready;
    logic                        o_pslverr;

    logic [WORD_WIDTH-1:0] model [$];
    int pushed_total = 0;
    int errors = 0;
    int test_errors = 0;
    int tests_run = 0;
    int cycles = 0;

    always #10 i_clk = ~i_clk;
    always #13 i_oclk = ~i_oclk;  // Slower readout domain.

    sym_out_top i_dut (.*);

    // A push seen here is written at the coming rising edge.
    always @(negedge i_clk) begin
        logic [WORD_WIDTH-1:0] w;
        if (!i_reset && i_push === 1'b1 && o_full === 1'b0) begin
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                w[SYM_WIDTH*c +: SYM_WIDTH] = i_data[c];
            end
            model.push_back(w);
            pushed_total++;
        end
    end

    always @(posedge i_oclk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d readout cycles, a transfer or a test never finished.",
                     cycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

    function automatic int sym_value(input logic [SYM_WIDTH-1:0] s);
        return s[SYM_WIDTH-1] ? int'(s) - (1 << SYM_WIDTH) : int'(s);  // Two's complement.
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        $display("test %s finished with %0d errors", name, errors - test_errors);
        test_errors = errors;
        tests_run++;
    endtask

    task automatic apb_transfer(input logic wr, input logic [APB_AW-1:0] addr,
                                input logic [APB_DW-1:0] wdata,
                                output logic [APB_DW-1:0] rdata, output logic err);
        @(posedge i_oclk);
        i_psel <= 1'b1;
        i_penable <= 1'b0;
        i_pwrite <= wr;
        i_paddr <= addr;
        i_pwdata <= wdata;
        @(posedge i_oclk);
        i_penable <= 1'b1;
        @(negedge i_oclk);
        while (o_pready !== 1'b1) begin
            @(negedge i_oclk);
        end
        rdata = o_prdata;
        err = o_pslverr;
        @(posedge i_oclk);
        i_psel <= 1'b0;
        i_penable <= 1'b0;
    endtask

    task automatic apb_read(input logic [APB_AW-1:0] addr,
                            output logic [APB_DW-1:0] rdata, output logic err);
        apb_transfer(1'b0, addr, '0, rdata, err);
    endtask

    // Compares a popped word against the model head, channel by channel.
    task automatic read_and_compare(input string name);
        logic [APB_DW-1:0] d;
        logic e;
        logic [WORD_WIDTH-1:0] exp_word;
        apb_read(REG_DATA, d, e);
        check({name, " error"}, 0, e);
        if (model.size() == 0) begin
            $display("%s: the DUT returned data but the model queue is empty", name);
            errors++;
        end else begin
            exp_word = model.pop_front();
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                check(name, sym_value(exp_word[SYM_WIDTH*c +: SYM_WIDTH]),
                      sym_value(d[SYM_WIDTH*c +: SYM_WIDTH]));
            end
            check({name, " upper bits"}, 0, d[APB_DW-1:WORD_WIDTH]);
        end
    endtask

    task automatic randomize_data();
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            i_data[c] <= SYM_WIDTH'($urandom);
        end
    endtask

    task automatic push_random(input int n);
        int target;
        target = pushed_total + n;
        while (pushed_total < target) begin
            @(posedge i_clk);
            if (pushed_total < target) begin
                i_push <= ($urandom % 2 == 0);  // Random gaps.
                randomize_data();
            end else begin
                i_push <= 1'b0;
            end
        end
    endtask

    task automatic fill_until_full();
        do begin
            @(posedge i_clk);
            i_push <= 1'b1;
            randomize_data();
            @(negedge i_clk);
        end while (o_full !== 1'b1);
        repeat (4) begin
            @(posedge i_clk);
            randomize_data();  // Pushes while full.
        end
        @(posedge i_clk);
        i_push <= 1'b0;
    endtask

    initial begin
        logic [APB_DW-1:0] d;
        logic [APB_DW-1:0] status;
        logic e;
        int popped;
        void'($urandom(32'h887a));
        i_reset = 1'b1;
        i_push = 1'b0;
        i_psel = 1'b0;
        i_penable = 1'b0;
        i_pwrite = 1'b0;
        i_paddr = '0;
        i_pwdata = '0;
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            i_data[c] = '0;
        end
        repeat (2) @(posedge i_clk);
        i_reset <= 1'b0;
        repeat (8) @(posedge i_oclk);

        apb_read(REG_ID, d, e);
        check("id value", {16'h0, 8'(SYM_WIDTH), 8'(NUM_CHANNELS)}, d);
        check("id error", 0, e);
        apb_read(4'hc, d, e);
        check("unmapped error", 1, e);
        end_test("id_and_unmapped");

        apb_read(REG_STATUS, d, e);
        check("reset status", 32'h1, d);
        apb_read(REG_DATA, d, e);
        check("empty data error", 1, e);
        check("empty data value", 0, d);
        @(negedge i_clk);
        check("reset full", 0, o_full);
        end_test("empty_after_reset");

        popped = 0;
        fork
            push_random(N_RANDOM);
            while (popped < N_RANDOM) begin
                apb_read(REG_STATUS, status, e);
                check("random status bound", 1, status[8 +: PTR_WIDTH] <= FIFO_DEPTH);
                if (!status[0]) begin
                    read_and_compare("random data");
                    popped++;
                end
            end
        join
        apb_read(REG_STATUS, d, e);
        check("random drained status", 32'h1, d);
        end_test("random_push_poll");

        fill_until_full();
        check("fill accepted", FIFO_DEPTH, model.size());
        repeat (6) @(posedge i_oclk);
        apb_read(REG_STATUS, status, e);
        check("fill count", model.size(), status[8 +: PTR_WIDTH]);
        check("fill empty flag", 0, status[0]);
        end_test("fill_and_count");

        for (int a = 0; a < 12; a += 4) begin
            apb_transfer(1'b1, APB_AW'(a), $urandom, d, e);
            check("write error", 0, e);
        end
        apb_read(REG_STATUS, d, e);
        check("status after writes", status, d);
        end_test("apb_writes");

        for (int i = 0; i < FIFO_DEPTH; i++) begin
            read_and_compare("drain data");
        end
        repeat (4) @(posedge i_oclk);
        apb_read(REG_STATUS, d, e);
        check("drained status", 32'h1, d);
        @(negedge i_clk);
        check("drained full", 0, o_full);
        end_test("drain");

        $display("%0d tests run, %0d errors", tests_run, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: filelist.f
rtl/sym_out_pkg.sv
rtl/sym_sync.sv
rtl/sym_async_fifo.sv
rtl/sym_apb_reader.sv
rtl/sym_out_top.sv
bench/sym_out_props.sv
bench/tb_sym_out.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_sym_out -f filelist.f -o sim_tb_sym_out

./obj_dir/sim_tb_sym_out > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
    exit 1
fi
grep -q "Simulation PASSED" sim.log
